// ==== serial_capture_trace.txt ====
# W order(m|l) hex-pattern, first bit sent is pattern bit 7 ; P nbits ; R hex-expected
# E pop while empty ; S count overflow ; C clear
W m b4
S 1 0
R b4
W l b4
R 2d
S 0 0
P 5
S 0 0
W m 3c
R 3c
W m 11
W m 22
W m 33
S 3 0
R 11
R 22
R 33
E
S 0 0
W m a1
W m a2
W m a3
W m a4
W m a5
S 4 1
R a1
R a2
R a3
R a4
S 0 1
W m 5a
S 1 1
C
S 0 0
E
W l 01
R 80
S 0 0

// ==== src.f ====
word_capture_pkg.sv
serial_sampler.sv
word_assembler.sv
word_fifo.sv
serial_capture_top.sv
serial_capture_checker.sv
serial_capture_tb.sv

// ==== Bender.yml ====
package:
  name: serial_capture

sources:
  - word_capture_pkg.sv
  - serial_sampler.sv
  - word_assembler.sv
  - word_fifo.sv
  - serial_capture_top.sv
  - target: simulation
    files:
      - serial_capture_checker.sv
      - serial_capture_tb.sv

// ==== serial_capture_tb.sv ====
// Serial word capture testbench
`timescale 1ns/1ps
`default_nettype none

module serial_capture_tb;

  import word_capture_pkg::*;

  localparam int fifo_depth = 4;
  localparam int phase_cycles = 4;
  localparam int timeout_cycles = 200;
  localparam int idle_cycles = 6;
  // Partial frame bits are sent from bit 7 down
  localparam logic [7:0] partial_pattern = 8'hd6;

  logic         clk;
  logic         reset_b;
  logic         serial_clk;
  logic         serial_data;
  logic         frame;
  logic         lsb_first;
  logic         rd_en;
  logic         clear;
  word_t        rd_data;
  fifo_status_t status;

  int errors;
  int checks;

  serial_capture_top #(
    .FIFO_DEPTH (fifo_depth)
  ) dut0 (
    .clk         (clk),
    .reset_b     (reset_b),
    .serial_clk  (serial_clk),
    .serial_data (serial_data),
    .frame       (frame),
    .lsb_first   (lsb_first),
    .rd_en       (rd_en),
    .clear       (clear),
    .rd_data     (rd_data),
    .status      (status)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Inputs change 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic check_value(input logic [15:0] actual, input logic [15:0] expected,
                             input string what);
    checks++;
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h",
               $time, what, actual, expected);
      errors++;
    end
  endtask

  //----------------------------------------
  // Serial side
  //----------------------------------------
  task automatic send_bit(input logic value);
    serial_data = value;
    serial_clk  = 1'b0;
    repeat (phase_cycles) next_cycle();
    serial_clk = 1'b1;
    repeat (phase_cycles) next_cycle();
  endtask

  // First bit on the line is pattern bit 7
  task automatic send_bits(input logic [7:0] pattern, input int nbits, input logic lsb);
    lsb_first = lsb;
    frame     = 1'b1;
    for (int i = 0; i < nbits; i++) begin
      send_bit(pattern[7-i]);
    end
  endtask

  task automatic end_frame();
    serial_clk = 1'b0;
    frame      = 1'b0;
    repeat (idle_cycles) next_cycle();
  endtask

  // A word either raises count or is dropped into overflow
  task automatic wait_word_landed(input logic [3:0] before_count);
    int cycles;
    cycles = 0;
    while (status.count == before_count && !(status.full && status.overflow) &&
           cycles < timeout_cycles) begin
      next_cycle();
      cycles++;
    end
    if (cycles >= timeout_cycles) begin
      $display("Timeout at %0t ns: a sent word never reached the FIFO", $time);
      errors++;
    end
  endtask

  //----------------------------------------
  // Host side
  //----------------------------------------
  task automatic pop_expect(input logic [7:0] expected);
    int cycles;
    cycles = 0;
    while (status.empty && cycles < timeout_cycles) begin
      next_cycle();
      cycles++;
    end
    if (status.empty) begin
      $display("Timeout at %0t ns: the FIFO stayed empty while a word was expected", $time);
      errors++;
    end else begin
      check_value(rd_data, expected, "popped word");
      rd_en = 1'b1;
      next_cycle();
      rd_en = 1'b0;
    end
  endtask

  task automatic pop_empty();
    check_value(status.empty, 1'b1, "empty before pop on empty FIFO");
    rd_en = 1'b1;
    next_cycle();
    rd_en = 1'b0;
    check_value(status.count, 4'd0, "count after pop on empty FIFO");
    check_value(status.empty, 1'b1, "empty after pop on empty FIFO");
  endtask

  task automatic check_status(input int exp_count, input int exp_ovf);
    check_value(status.count, exp_count, "status count");
    check_value(status.overflow, exp_ovf, "status overflow");
    check_value(status.full, exp_count == fifo_depth, "status full");
    check_value(status.empty, exp_count == 0, "status empty");
  endtask

  task automatic clear_fifo();
    clear = 1'b1;
    next_cycle();
    clear = 1'b0;
  endtask

  //----------------------------------------
  // Trace interpreter
  //----------------------------------------
  task automatic run_trace();
    int              fd;
    int              rc;
    int              n;
    int              exp_count;
    int              exp_ovf;
    logic [63:0]     cmd;
    logic [7:0]      order;
    logic [7:0]      value;
    logic [3:0]      before_count;
    logic [8*256-1:0] line;
    fd = $fopen("serial_capture_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file serial_capture_trace.txt");
      errors++;
    end else begin
      while ($fscanf(fd, "%s", cmd) == 1) begin
        if (cmd == "#") begin
          rc = $fgets(line, fd);
        end else if (cmd == "W") begin
          rc = $fscanf(fd, "%s %h", order, value);
          before_count = status.count;
          send_bits(value, word_bits, order == "l");
          wait_word_landed(before_count);
          end_frame();
        end else if (cmd == "P") begin
          rc = $fscanf(fd, "%d", n);
          send_bits(partial_pattern, n, 1'b0);
          end_frame();
        end else if (cmd == "R") begin
          rc = $fscanf(fd, "%h", value);
          pop_expect(value);
        end else if (cmd == "E") begin
          pop_empty();
        end else if (cmd == "S") begin
          rc = $fscanf(fd, "%d %d", exp_count, exp_ovf);
          check_status(exp_count, exp_ovf);
        end else if (cmd == "C") begin
          clear_fifo();
        end else begin
          $display("The trace file holds an unknown command %0s", cmd);
          errors++;
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    errors      = 0;
    checks      = 0;
    reset_b     = 1'b0;
    serial_clk  = 1'b0;
    serial_data = 1'b0;
    frame       = 1'b0;
    lsb_first   = 1'b0;
    rd_en       = 1'b0;
    clear       = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    reset_b = 1'b1;
    next_cycle();
    check_status(0, 0);
    run_trace();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== serial_capture_checker.sv ====
// FIFO status assertions
`timescale 1ns/1ps
`default_nettype none

module serial_capture_checker #(
  parameter int FIFO_DEPTH = 4
) (
  input logic                            clk,
  input logic                            reset_b,
  input logic                            clear,
  input word_capture_pkg::fifo_status_t  status
);

  import word_capture_pkg::*;

  count_in_range: assert property (@(posedge clk) disable iff (!reset_b)
    status.count <= FIFO_DEPTH)
    else $error("FIFO count above its depth");

  full_matches_count: assert property (@(posedge clk) disable iff (!reset_b)
    status.full == (status.count == FIFO_DEPTH))
    else $error("FIFO full flag disagrees with count");

  empty_matches_count: assert property (@(posedge clk) disable iff (!reset_b)
    status.empty == (status.count == 0))
    else $error("FIFO empty flag disagrees with count");

  // Clear wins over any write in the same cycle
  clear_empties: assert property (@(posedge clk) disable iff (!reset_b)
    clear |=> (status.empty && !status.overflow))
    else $error("FIFO not empty or overflow still set after clear");

endmodule

bind word_fifo serial_capture_checker #(
  .FIFO_DEPTH (FIFO_DEPTH)
) u_checker (
  .clk     (clk),
  .reset_b (reset_b),
  .clear   (clear),
  .status  (status)
);

`default_nettype wire

// ==== serial_capture_top.sv ====
// Serial word capture top level
`timescale 1ns/1ps
`default_nettype none

module serial_capture_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                            clk,
  input  logic                            reset_b,
  input  logic                            serial_clk,
  input  logic                            serial_data,
  input  logic                            frame,
  input  logic                            lsb_first,
  input  logic                            rd_en,
  input  logic                            clear,
  output word_capture_pkg::word_t         rd_data,
  output word_capture_pkg::fifo_status_t  status
);

  import word_capture_pkg::*;

  sample_t sample;
  word_t   word_data;
  logic    word_valid;

  //----------------------------------------
  // Input side
  //----------------------------------------
  serial_sampler u_sampler (
    .clk         (clk),
    .reset_b     (reset_b),
    .serial_clk  (serial_clk),
    .serial_data (serial_data),
    .frame       (frame),
    .sample      (sample)
  );

  // Bit collection
  word_assembler u_assembler (
    .clk        (clk),
    .reset_b    (reset_b),
    .sample     (sample),
    .lsb_first  (lsb_first),
    .word_data  (word_data),
    .word_valid (word_valid)
  );

  //----------------------------------------
  // Output side
  //----------------------------------------
  word_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk        (clk),
    .reset_b    (reset_b),
    .word_data  (word_data),
    .word_valid (word_valid),
    .rd_en      (rd_en),
    .clear      (clear),
    .rd_data    (rd_data),
    .status     (status)
  );

endmodule

`default_nettype wire

// ==== word_fifo.sv ====
// Word FIFO with first-word fall-through
`timescale 1ns/1ps
`default_nettype none

module word_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                            clk,
  input  logic                            reset_b,
  input  word_capture_pkg::word_t         word_data,
  input  logic                            word_valid,
  input  logic                            rd_en,
  input  logic                            clear,
  output word_capture_pkg::word_t         rd_data,
  output word_capture_pkg::fifo_status_t  status
);

  import word_capture_pkg::*;

  localparam int ptr_bits   = $clog2(FIFO_DEPTH);
  localparam int count_bits = $bits(status.count);
  localparam logic [count_bits-1:0] depth_count = count_bits'(FIFO_DEPTH);

  word_t               mem [FIFO_DEPTH];
  logic [ptr_bits-1:0] wr_ptr;
  logic [ptr_bits-1:0] rd_ptr;
  logic [count_bits-1:0] count;
  logic                empty;
  logic                full;
  logic                overflow;
  logic                wr_fire;
  logic                rd_fire;

  assign empty   = (count == '0);
  assign full    = (count == depth_count);
  assign wr_fire = word_valid & ~full;
  assign rd_fire = rd_en & ~empty;

  //----------------------------------------
  // Storage and pointers
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= word_data;
    end
  end

  // Depth is a power of two so the pointers wrap on their own
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_fire) wr_ptr <= wr_ptr + 1'b1;
      if (rd_fire) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  //----------------------------------------
  // Occupancy and overflow
  //----------------------------------------
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      count    <= '0;
      overflow <= 1'b0;
    end else if (clear) begin
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      case ({wr_fire, rd_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // A dropped word sets the sticky flag
      if (word_valid && full) overflow <= 1'b1;
    end
  end

  // Head word is visible without a read delay
  assign rd_data = mem[rd_ptr];

  assign status = '{count: count, empty: empty, full: full, overflow: overflow};

endmodule

`default_nettype wire

// ==== word_assembler.sv ====
// Serial to parallel word assembler
`timescale 1ns/1ps
`default_nettype none

module word_assembler (
  input  logic                       clk,
  input  logic                       reset_b,
  input  word_capture_pkg::sample_t  sample,
  input  logic                       lsb_first,
  output word_capture_pkg::word_t    word_data,
  output logic                       word_valid
);

  import word_capture_pkg::*;

  localparam int cnt_bits = $clog2(word_bits);
  localparam logic [cnt_bits-1:0] last_bit = cnt_bits'(word_bits - 1);

  shift_op_e           shift_op;
  logic [cnt_bits-1:0] bit_count;
  logic                bit_take;
  word_t               shift_q;

  // A bit counts only inside a frame
  assign bit_take = sample.bit_strobe & sample.framed;

  //----------------------------------------
  // Opcode decode
  //----------------------------------------
  always_comb begin
    if (!sample.framed) begin
      shift_op = op_clear;
    end else if (sample.bit_strobe) begin
      // LSB first enters at the top and walks down to bit 0
      shift_op = lsb_first ? op_shift_right : op_shift_left;
    end else begin
      shift_op = op_hold;
    end
  end

  //----------------------------------------
  // Universal shift register
  //----------------------------------------
  always_ff @(posedge clk) begin
    case (shift_op)
      op_hold:        shift_q <= shift_q;
      op_shift_right: shift_q <= {sample.bit_value, shift_q[word_bits-1:1]};
      op_shift_left:  shift_q <= {shift_q[word_bits-2:0], sample.bit_value};
      op_clear:       shift_q <= '0;
      default:        shift_q <= shift_q;
    endcase
  end

  //----------------------------------------
  // Mod-8 bit counter and word strobe
  //----------------------------------------
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      bit_count  <= '0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= bit_take && (bit_count == last_bit);
      if (shift_op == op_clear) begin
        bit_count <= '0;
      end else if (bit_take) begin
        // Wraps to zero after the last bit of a word
        bit_count <= bit_count + 1'b1;
      end
    end
  end

  assign word_data = shift_q;

endmodule

`default_nettype wire

// ==== serial_sampler.sv ====
// Serial line sampler
`timescale 1ns/1ps
`default_nettype none

module serial_sampler (
  input  logic                       clk,
  input  logic                       reset_b,
  input  logic                       serial_clk,
  input  logic                       serial_data,
  input  logic                       frame,
  output word_capture_pkg::sample_t  sample
);

  // Bit positions in the synchronizer vector
  localparam int idx_clk   = 0;
  localparam int idx_data  = 1;
  localparam int idx_frame = 2;

  logic [2:0] async_in;
  logic [2:0] sync_meta;
  logic [2:0] sync_out;
  logic       clk_hist;

  assign async_in = {frame, serial_data, serial_clk};

  //----------------------------------------
  // Two-flop synchronizers
  //----------------------------------------
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      sync_meta <= '0;
      sync_out  <= '0;
    end else begin
      sync_meta <= async_in;
      sync_out  <= sync_meta;
    end
  end

  //----------------------------------------
  // Rising edge of the serial clock
  //----------------------------------------
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      clk_hist <= 1'b0;
    end else begin
      clk_hist <= sync_out[idx_clk];
    end
  end

  // Strobe is high for the one cycle where the new level is seen
  assign sample.bit_strobe = sync_out[idx_clk] & ~clk_hist;
  // Data and frame share the same two stages as the clock
  assign sample.bit_value  = sync_out[idx_data];
  assign sample.framed     = sync_out[idx_frame];

endmodule

`default_nettype wire

// ==== word_capture_pkg.sv ====
// Serial word capture shared types
`default_nettype none

package word_capture_pkg;

  // Bits per captured word
  localparam int word_bits = 8;

  typedef logic [word_bits-1:0] word_t;

  //----------------------------------------
  // Shift register opcode
  //----------------------------------------
  typedef enum logic [1:0] {
    op_hold        = 2'b00,
    op_shift_right = 2'b01,
    op_shift_left  = 2'b10,
    op_clear       = 2'b11
  } shift_op_e;

  // Sampler to assembler
  typedef struct packed {
    logic bit_strobe;
    logic bit_value;
    logic framed;
  } sample_t;

  // FIFO status with a count for depths up to 8
  typedef struct packed {
    logic [3:0] count;
    logic       empty;
    logic       full;
    logic       overflow;
  } fifo_status_t;

endpackage

`default_nettype wire
